// ==== verilog/hdr_config.svh ====
// **************************************************
// Widths for the header encapsulation datapath
// **************************************************
`ifndef HDR_CONFIG_SVH
`define HDR_CONFIG_SVH

// Stream data bus and header, the header is narrower than the bus
`define HDR_DATA_W  64
`define HDR_HDR_W   32
`define HDR_KEEP_W  (`HDR_DATA_W / 8)
`define HDR_HKEEP_W (`HDR_HDR_W / 8)

`define HDR_DEST_W  4
`define HDR_USER_W  4
`define HDR_APB_AW  4

`endif

// ==== verilog/hdr_pkg.sv ====
// **************************************************
// Framing state and register address types
// **************************************************
`include "hdr_config.svh"

package hdr_pkg;

  // Shared by the adder and the remover
  typedef enum logic [1:0] {
    ST_HDR = 2'd0,
    ST_MID = 2'd1,
    ST_LST = 2'd2,
    ST_FWD = 2'd3
  } hdr_state_e;

  typedef enum logic [`HDR_APB_AW-1:0] {
    CSR_CTRL   = 4'h0,
    CSR_TX_HDR = 4'h4,
    CSR_RX_HDR = 4'h8,
    CSR_COUNTS = 4'hc
  } csr_addr_e;

endpackage

// ==== verilog/header_adder.sv ====
// **************************************************
// Transmit framer, prepends the header to a packet
// **************************************************
`timescale 1ns/1ns
`include "hdr_config.svh"

module header_adder import hdr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`HDR_DATA_W-1:0] s_tdata,
  input  logic [`HDR_KEEP_W-1:0] s_tkeep,
  input  logic [`HDR_DEST_W-1:0] s_tdest,
  input  logic [`HDR_USER_W-1:0] s_tuser,
  input  logic                   s_tlast,
  input  logic                   s_tvalid,
  output logic                   s_tready,
  input  logic [`HDR_HDR_W-1:0]  header,
  input  logic                   header_valid,
  output logic                   header_ready,
  output logic [`HDR_DATA_W-1:0] m_tdata,
  output logic [`HDR_KEEP_W-1:0] m_tkeep,
  output logic [`HDR_DEST_W-1:0] m_tdest,
  output logic [`HDR_USER_W-1:0] m_tuser,
  output logic                   m_tlast,
  output logic                   m_tvalid,
  input  logic                   m_tready
);

  // Part of an input word that lands in the same output word
  localparam int LO_W = `HDR_DATA_W - `HDR_HDR_W;
  localparam int LO_K = `HDR_KEEP_W - `HDR_HKEEP_W;

  hdr_state_e             state;
  logic [`HDR_HDR_W-1:0]  rest_data;
  logic [`HDR_HKEEP_W-1:0] rest_keep;
  logic [`HDR_DEST_W-1:0] dest_q;
  logic [`HDR_USER_W-1:0] user_q;
  logic                   s_fire;
  logic                   upper_kept;

  assign s_fire = s_tvalid && s_tready;
  // Bytes pushed past the end of the current output word
  assign upper_kept = |s_tkeep[`HDR_KEEP_W-1:LO_K];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else begin
      case (state)
        ST_HDR: if (s_fire) begin
          if (header_valid) begin
            state <= s_tlast ? (upper_kept ? ST_LST : ST_HDR) : ST_MID;
          end else begin
            state <= s_tlast ? ST_HDR : ST_FWD;
          end
        end
        ST_MID: if (s_fire && s_tlast) begin
          state <= upper_kept ? ST_LST : ST_HDR;
        end
        ST_LST: if (m_tready) state <= ST_HDR;
        ST_FWD: if (s_fire && s_tlast) state <= ST_HDR;
      endcase
    end
  end

  // Carry the upper part of every accepted word into the next output word
  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_data <= s_tdata[`HDR_DATA_W-1:LO_W];
      rest_keep <= s_tkeep[`HDR_KEEP_W-1:LO_K];
    end
    if (s_fire && state == ST_HDR) begin
      dest_q <= s_tdest;
      user_q <= s_tuser;
    end
  end

  always_comb begin
    m_tdata = s_tdata;
    m_tkeep = s_tkeep;
    m_tlast = s_tlast;
    case (state)
      ST_HDR: if (header_valid) begin
        m_tdata = {s_tdata[LO_W-1:0], header};
        m_tkeep = {s_tkeep[LO_K-1:0], {`HDR_HKEEP_W{1'b1}}};
        m_tlast = s_tlast && !upper_kept;
      end
      ST_MID: begin
        m_tdata = {s_tdata[LO_W-1:0], rest_data};
        m_tkeep = {s_tkeep[LO_K-1:0], rest_keep};
        m_tlast = s_tlast && !upper_kept;
      end
      ST_LST: begin
        m_tdata = {{LO_W{1'b0}}, rest_data};
        m_tkeep = {{LO_K{1'b0}}, rest_keep};
        m_tlast = 1'b1;
      end
      default: ;
    endcase
  end

  assign m_tvalid = (state == ST_LST) ? 1'b1 : s_tvalid;
  assign m_tdest  = (state == ST_HDR) ? s_tdest : dest_q;
  assign m_tuser  = (state == ST_HDR) ? s_tuser : user_q;
  // Input stalls for the one cycle the tail word goes out
  assign s_tready = (state == ST_LST) ? 1'b0 : m_tready;
  assign header_ready = (state == ST_HDR) && header_valid && s_tvalid && m_tready;

endmodule

// ==== verilog/header_remover.sv ====
// **************************************************
// Receive deframer, strips the header off a packet
// **************************************************
`timescale 1ns/1ns
`include "hdr_config.svh"

module header_remover import hdr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   has_header,
  input  logic [`HDR_DATA_W-1:0] s_tdata,
  input  logic [`HDR_KEEP_W-1:0] s_tkeep,
  input  logic [`HDR_DEST_W-1:0] s_tdest,
  input  logic [`HDR_USER_W-1:0] s_tuser,
  input  logic                   s_tlast,
  input  logic                   s_tvalid,
  output logic                   s_tready,
  output logic [`HDR_HDR_W-1:0]  header,
  output logic                   header_valid,
  output logic [`HDR_DATA_W-1:0] m_tdata,
  output logic [`HDR_KEEP_W-1:0] m_tkeep,
  output logic [`HDR_DEST_W-1:0] m_tdest,
  output logic [`HDR_USER_W-1:0] m_tuser,
  output logic                   m_tlast,
  output logic                   m_tvalid,
  input  logic                   m_tready
);

  // Payload part of an input word that follows the header bytes
  localparam int HI_W = `HDR_DATA_W - `HDR_HDR_W;
  localparam int HI_K = `HDR_KEEP_W - `HDR_HKEEP_W;

  hdr_state_e             state;
  logic [`HDR_HDR_W-1:0]  header_q;
  logic [HI_W-1:0]        rest_data;
  logic [HI_K-1:0]        rest_keep;
  logic [`HDR_DEST_W-1:0] dest_q;
  logic [`HDR_USER_W-1:0] user_q;
  logic                   s_fire;
  logic                   upper_kept;

  assign s_fire = s_tvalid && s_tready;
  // The word still has bytes left over after its low part was used
  assign upper_kept = |s_tkeep[`HDR_KEEP_W-1:`HDR_HKEEP_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else begin
      case (state)
        ST_HDR: if (s_fire && !s_tlast) begin
          state <= has_header ? ST_MID : ST_FWD;
        end
        ST_MID: if (s_fire && s_tlast) begin
          state <= upper_kept ? ST_LST : ST_HDR;
        end
        ST_LST: if (m_tready) state <= ST_HDR;
        ST_FWD: if (s_fire && s_tlast) state <= ST_HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_data <= s_tdata[`HDR_DATA_W-1:`HDR_HDR_W];
      rest_keep <= s_tkeep[`HDR_KEEP_W-1:`HDR_HKEEP_W];
    end
    if (s_fire && state == ST_HDR) begin
      header_q <= s_tdata[`HDR_HDR_W-1:0];
      dest_q   <= s_tdest;
      user_q   <= s_tuser;
    end
  end

  always_comb begin
    m_tdata  = s_tdata;
    m_tkeep  = s_tkeep;
    m_tlast  = s_tlast;
    m_tvalid = s_tvalid;
    case (state)
      ST_HDR: if (has_header) begin
        // A multi-word packet loses its first word here, only a
        // single-word packet produces output straight away
        m_tdata  = {{`HDR_HDR_W{1'b0}}, s_tdata[`HDR_DATA_W-1:`HDR_HDR_W]};
        m_tkeep  = {{`HDR_HKEEP_W{1'b0}}, s_tkeep[`HDR_KEEP_W-1:`HDR_HKEEP_W]};
        m_tvalid = s_tvalid && s_tlast;
      end
      ST_MID: begin
        m_tdata = {s_tdata[`HDR_HDR_W-1:0], rest_data};
        m_tkeep = {s_tkeep[`HDR_HKEEP_W-1:0], rest_keep};
        m_tlast = s_tlast && !upper_kept;
      end
      ST_LST: begin
        m_tdata  = {{`HDR_HDR_W{1'b0}}, rest_data};
        m_tkeep  = {{`HDR_HKEEP_W{1'b0}}, rest_keep};
        m_tlast  = 1'b1;
        m_tvalid = 1'b1;
      end
      default: ;
    endcase
  end

  assign m_tdest = (state == ST_HDR) ? s_tdest : dest_q;
  assign m_tuser = (state == ST_HDR) ? s_tuser : user_q;

  // The first word of a stripped multi-word packet is taken without output
  always_comb begin
    case (state)
      ST_HDR:  s_tready = has_header ? (!s_tlast || m_tready) : m_tready;
      ST_LST:  s_tready = 1'b0;
      default: s_tready = m_tready;
    endcase
  end

  assign header       = (state == ST_HDR) ? s_tdata[`HDR_HDR_W-1:0] : header_q;
  assign header_valid = (state == ST_HDR && has_header && s_tvalid) ||
                        state == ST_MID || state == ST_LST;

endmodule

// ==== verilog/hdr_csr.sv ====
// **************************************************
// APB registers: control, headers, packet counters
// **************************************************
`timescale 1ns/1ns
`include "hdr_config.svh"

module hdr_csr import hdr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`HDR_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  input  logic                   tx_hdr_taken,
  input  logic [`HDR_HDR_W-1:0]  rx_header,
  input  logic                   rx_header_valid,
  input  logic                   rx_pkt_done,
  output logic [`HDR_HDR_W-1:0]  tx_header,
  output logic                   add_en,
  output logic                   strip_en
);

  logic [`HDR_HDR_W-1:0] rx_hdr_q;
  logic [15:0]           tx_count;
  logic [15:0]           rx_count;
  logic                  hdr_armed;
  logic                  apb_wr;

  // Writes complete in the access phase, no wait states
  assign apb_wr = psel && penable && pwrite;

  always_ff @(posedge clk) begin
    if (rst) begin
      add_en    <= 1'b0;
      strip_en  <= 1'b0;
      tx_header <= '0;
      rx_hdr_q  <= '0;
      tx_count  <= '0;
      rx_count  <= '0;
      hdr_armed <= 1'b1;
    end else begin
      if (apb_wr && csr_addr_e'(paddr) == CSR_CTRL) begin
        add_en   <= pwdata[0];
        strip_en <= pwdata[1];
      end
      if (apb_wr && csr_addr_e'(paddr) == CSR_TX_HDR) tx_header <= pwdata[`HDR_HDR_W-1:0];
      // Take the header once per packet, on its first cycle of header_valid
      if (rx_header_valid && hdr_armed) rx_hdr_q <= rx_header;
      if (rx_pkt_done) begin
        hdr_armed <= 1'b1;
      end else if (rx_header_valid) begin
        hdr_armed <= 1'b0;
      end
      if (tx_hdr_taken) tx_count <= tx_count + 16'd1;
      if (rx_pkt_done) rx_count <= rx_count + 16'd1;
    end
  end

  always_comb begin
    case (csr_addr_e'(paddr))
      CSR_CTRL:   prdata = {30'd0, strip_en, add_en};
      CSR_TX_HDR: prdata = tx_header;
      CSR_RX_HDR: prdata = rx_hdr_q;
      CSR_COUNTS: prdata = {rx_count, tx_count};
      default:    prdata = '0;
    endcase
  end

endmodule

// ==== verilog/hdr_encap_top.sv ====
// **************************************************
// Encapsulation top: adder, remover and registers
// **************************************************
`timescale 1ns/1ns
`include "hdr_config.svh"

module hdr_encap_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`HDR_DATA_W-1:0] tx_s_tdata,
  input  logic [`HDR_KEEP_W-1:0] tx_s_tkeep,
  input  logic [`HDR_DEST_W-1:0] tx_s_tdest,
  input  logic [`HDR_USER_W-1:0] tx_s_tuser,
  input  logic                   tx_s_tlast,
  input  logic                   tx_s_tvalid,
  output logic                   tx_s_tready,
  output logic [`HDR_DATA_W-1:0] tx_m_tdata,
  output logic [`HDR_KEEP_W-1:0] tx_m_tkeep,
  output logic [`HDR_DEST_W-1:0] tx_m_tdest,
  output logic [`HDR_USER_W-1:0] tx_m_tuser,
  output logic                   tx_m_tlast,
  output logic                   tx_m_tvalid,
  input  logic                   tx_m_tready,
  input  logic [`HDR_DATA_W-1:0] rx_s_tdata,
  input  logic [`HDR_KEEP_W-1:0] rx_s_tkeep,
  input  logic [`HDR_DEST_W-1:0] rx_s_tdest,
  input  logic [`HDR_USER_W-1:0] rx_s_tuser,
  input  logic                   rx_s_tlast,
  input  logic                   rx_s_tvalid,
  output logic                   rx_s_tready,
  output logic [`HDR_DATA_W-1:0] rx_m_tdata,
  output logic [`HDR_KEEP_W-1:0] rx_m_tkeep,
  output logic [`HDR_DEST_W-1:0] rx_m_tdest,
  output logic [`HDR_USER_W-1:0] rx_m_tuser,
  output logic                   rx_m_tlast,
  output logic                   rx_m_tvalid,
  input  logic                   rx_m_tready,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`HDR_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata
);

  logic [`HDR_HDR_W-1:0] tx_header;
  logic [`HDR_HDR_W-1:0] rx_header;
  logic                  add_en;
  logic                  strip_en;
  logic                  tx_hdr_taken;
  logic                  rx_header_valid;
  logic                  rx_pkt_done;

  // One completed packet on the receive output
  assign rx_pkt_done = rx_m_tvalid && rx_m_tready && rx_m_tlast;

  header_adder u_adder (
    .clk          (clk),
    .rst          (rst),
    .s_tdata      (tx_s_tdata),
    .s_tkeep      (tx_s_tkeep),
    .s_tdest      (tx_s_tdest),
    .s_tuser      (tx_s_tuser),
    .s_tlast      (tx_s_tlast),
    .s_tvalid     (tx_s_tvalid),
    .s_tready     (tx_s_tready),
    .header       (tx_header),
    .header_valid (add_en),
    .header_ready (tx_hdr_taken),
    .m_tdata      (tx_m_tdata),
    .m_tkeep      (tx_m_tkeep),
    .m_tdest      (tx_m_tdest),
    .m_tuser      (tx_m_tuser),
    .m_tlast      (tx_m_tlast),
    .m_tvalid     (tx_m_tvalid),
    .m_tready     (tx_m_tready)
  );

  header_remover u_remover (
    .clk          (clk),
    .rst          (rst),
    .has_header   (strip_en),
    .s_tdata      (rx_s_tdata),
    .s_tkeep      (rx_s_tkeep),
    .s_tdest      (rx_s_tdest),
    .s_tuser      (rx_s_tuser),
    .s_tlast      (rx_s_tlast),
    .s_tvalid     (rx_s_tvalid),
    .s_tready     (rx_s_tready),
    .header       (rx_header),
    .header_valid (rx_header_valid),
    .m_tdata      (rx_m_tdata),
    .m_tkeep      (rx_m_tkeep),
    .m_tdest      (rx_m_tdest),
    .m_tuser      (rx_m_tuser),
    .m_tlast      (rx_m_tlast),
    .m_tvalid     (rx_m_tvalid),
    .m_tready     (rx_m_tready)
  );

  hdr_csr u_csr (
    .clk             (clk),
    .rst             (rst),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .tx_hdr_taken    (tx_hdr_taken),
    .rx_header       (rx_header),
    .rx_header_valid (rx_header_valid),
    .rx_pkt_done     (rx_pkt_done),
    .tx_header       (tx_header),
    .add_en          (add_en),
    .strip_en        (strip_en)
  );

endmodule

// ==== test/tb_clock.sv ====
// **************************************************
// Testbench clock (40 ns) and reset generator
// **************************************************
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset covers the first two clock periods
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== test/tb_hdr_encap.sv ====
// **************************************************
// Testbench for the header encapsulation top level
// Packet table, stream driver, monitors, compare tasks
// **************************************************
`timescale 1ns/1ns
`include "hdr_config.svh"

module tb_hdr_encap import hdr_pkg::*; ();

  typedef struct packed {
    logic [7:0]             len;
    logic                   add;
    logic                   strip;
    logic [`HDR_HDR_W-1:0]  hdr;
    logic [`HDR_DEST_W-1:0] dest;
    logic [`HDR_USER_W-1:0] user;
    logic                   bp;
  } row_t;

  logic clk;
  logic rst;
  logic [`HDR_DATA_W-1:0] tx_s_tdata;
  logic [`HDR_KEEP_W-1:0] tx_s_tkeep;
  logic [`HDR_DEST_W-1:0] tx_s_tdest;
  logic [`HDR_USER_W-1:0] tx_s_tuser;
  logic tx_s_tlast;
  logic tx_s_tvalid;
  logic tx_s_tready;
  // The transmit output loops back into the receive input
  logic [`HDR_DATA_W-1:0] tx_m_tdata;
  logic [`HDR_KEEP_W-1:0] tx_m_tkeep;
  logic [`HDR_DEST_W-1:0] tx_m_tdest;
  logic [`HDR_USER_W-1:0] tx_m_tuser;
  logic tx_m_tlast;
  logic tx_m_tvalid;
  logic tx_m_tready;
  logic [`HDR_DATA_W-1:0] rx_m_tdata;
  logic [`HDR_KEEP_W-1:0] rx_m_tkeep;
  logic [`HDR_DEST_W-1:0] rx_m_tdest;
  logic [`HDR_USER_W-1:0] rx_m_tuser;
  logic rx_m_tlast;
  logic rx_m_tvalid;
  logic rx_m_tready;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`HDR_APB_AW-1:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;

  row_t rows[$];
  row_t cur;
  logic [7:0] pay [0:63];
  logic [`HDR_DATA_W+`HDR_KEEP_W:0] exp_tx[$];
  logic [`HDR_DATA_W+`HDR_KEEP_W:0] exp_rx[$];
  logic [31:0] pay_lfsr;
  logic [31:0] rdy_lfsr;
  logic bp_on;
  logic [15:0] exp_tx_cnt;
  logic [15:0] exp_rx_cnt;
  int err_count;
  int n_checks;
  bit timed_out;

  tb_clock u_clock (.clk(clk), .rst(rst));

  hdr_encap_top u_dut (
    .clk(clk), .rst(rst),
    .tx_s_tdata(tx_s_tdata), .tx_s_tkeep(tx_s_tkeep), .tx_s_tdest(tx_s_tdest),
    .tx_s_tuser(tx_s_tuser), .tx_s_tlast(tx_s_tlast), .tx_s_tvalid(tx_s_tvalid),
    .tx_s_tready(tx_s_tready),
    .tx_m_tdata(tx_m_tdata), .tx_m_tkeep(tx_m_tkeep), .tx_m_tdest(tx_m_tdest),
    .tx_m_tuser(tx_m_tuser), .tx_m_tlast(tx_m_tlast), .tx_m_tvalid(tx_m_tvalid),
    .tx_m_tready(tx_m_tready),
    .rx_s_tdata(tx_m_tdata), .rx_s_tkeep(tx_m_tkeep), .rx_s_tdest(tx_m_tdest),
    .rx_s_tuser(tx_m_tuser), .rx_s_tlast(tx_m_tlast), .rx_s_tvalid(tx_m_tvalid),
    .rx_s_tready(tx_m_tready),
    .rx_m_tdata(rx_m_tdata), .rx_m_tkeep(rx_m_tkeep), .rx_m_tdest(rx_m_tdest),
    .rx_m_tuser(rx_m_tuser), .rx_m_tlast(rx_m_tlast), .rx_m_tvalid(rx_m_tvalid),
    .rx_m_tready(rx_m_tready),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1 feeding the new bit into bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      pay_lfsr = lfsr_next(pay_lfsr);
      b = {b[6:0], pay_lfsr[0]};
    end
  endtask

  // Receive back-pressure takes one LFSR bit per cycle while enabled
  always @(negedge clk) begin
    if (bp_on) begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      rx_m_tready <= rdy_lfsr[0];
    end else begin
      rx_m_tready <= 1'b1;
    end
  end

  task automatic check_word(input string port,
                            input logic [`HDR_DATA_W-1:0] exp_d,
                            input logic [`HDR_KEEP_W-1:0] exp_k,
                            input logic exp_l,
                            input logic [`HDR_DATA_W-1:0] got_d,
                            input logic [`HDR_KEEP_W-1:0] got_k,
                            input logic got_l);
    n_checks++;
    if (got_d !== exp_d) begin
      err_count++;
      $display("ERR %s_tdata expected 0x%h got 0x%h", port, exp_d, got_d);
    end
    if (got_k !== exp_k) begin
      err_count++;
      $display("ERR %s_tkeep expected 0x%h got 0x%h", port, exp_k, got_k);
    end
    if (got_l !== exp_l) begin
      err_count++;
      $display("ERR %s_tlast expected 0x%h got 0x%h", port, exp_l, got_l);
    end
  endtask

  task automatic check_side(input string port,
                            input logic [`HDR_DEST_W-1:0] exp_dest,
                            input logic [`HDR_USER_W-1:0] exp_user,
                            input logic [`HDR_DEST_W-1:0] got_dest,
                            input logic [`HDR_USER_W-1:0] got_user);
    n_checks++;
    if (got_dest !== exp_dest || got_user !== exp_user) begin
      err_count++;
      $display("ERR %s_tdest/tuser expected 0x%h/0x%h got 0x%h/0x%h",
               port, exp_dest, exp_user, got_dest, got_user);
    end
  endtask

  task automatic check_hdr(input string name, input logic [`HDR_HDR_W-1:0] exp_h,
                           input logic [`HDR_HDR_W-1:0] got_h);
    n_checks++;
    if (got_h !== exp_h) begin
      err_count++;
      $display("ERR %s expected 0x%h got 0x%h", name, exp_h, got_h);
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] exp_c,
                             input logic [15:0] got_c);
    n_checks++;
    if (got_c !== exp_c) begin
      err_count++;
      $display("ERR %s expected 0x%h got 0x%h", name, exp_c, got_c);
    end
  endtask

  task automatic check_state_free(input csr_addr_e addr, input logic [31:0] exp_v,
                                  input logic [31:0] got_v);
    n_checks++;
    if (got_v !== exp_v) begin
      err_count++;
      $display("ERR prdata at %s expected 0x%h got 0x%h", addr.name(), exp_v, got_v);
    end
  endtask

  task automatic apb_write(input csr_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input csr_addr_e addr, output logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // Expected byte i on tx_m or on rx_m when rx_path is set
  function automatic logic [7:0] stream_byte(input bit rx_path, input int i);
    if (!cur.add || (rx_path && cur.strip)) return pay[i];
    if (i < `HDR_HKEEP_W) return cur.hdr[8*i +: 8];
    return pay[i - `HDR_HKEEP_W];
  endfunction

  task automatic expect_stream(input bit rx_path, input int len);
    logic [`HDR_DATA_W-1:0] d;
    logic [`HDR_KEEP_W-1:0] k;
    int nw;
    int idx;
    nw = (len + `HDR_KEEP_W - 1) / `HDR_KEEP_W;
    for (int w = 0; w < nw; w++) begin
      d = '0;
      k = '0;
      for (int b = 0; b < `HDR_KEEP_W; b++) begin
        idx = w * `HDR_KEEP_W + b;
        if (idx < len) begin
          d[8*b +: 8] = stream_byte(rx_path, idx);
          k[b] = 1'b1;
        end
      end
      if (rx_path) exp_rx.push_back({w == nw - 1, k, d});
      else exp_tx.push_back({w == nw - 1, k, d});
    end
  endtask

  task automatic drive_packet();
    logic [`HDR_DATA_W-1:0] d;
    logic [`HDR_KEEP_W-1:0] k;
    int nw;
    int cnt;
    bit taken;
    nw = (cur.len + `HDR_KEEP_W - 1) / `HDR_KEEP_W;
    for (int w = 0; w < nw && !timed_out; w++) begin
      d = '0;
      k = '0;
      for (int b = 0; b < `HDR_KEEP_W; b++) begin
        if (w * `HDR_KEEP_W + b < cur.len) begin
          d[8*b +: 8] = pay[w * `HDR_KEEP_W + b];
          k[b] = 1'b1;
        end
      end
      @(negedge clk);
      tx_s_tdata = d;
      tx_s_tkeep = k;
      tx_s_tlast = (w == nw - 1);
      // Only the first word's tdest and tuser may reach the output
      tx_s_tdest = (w == 0) ? cur.dest : ~cur.dest;
      tx_s_tuser = (w == 0) ? cur.user : ~cur.user;
      tx_s_tvalid = 1'b1;
      taken = 1'b0;
      cnt = 0;
      while (!taken && cnt < 200) begin
        @(posedge clk);
        taken = tx_s_tready;
        cnt++;
      end
      if (!taken) begin
        err_count++;
        timed_out = 1'b1;
        $display("timeout: tx_s word %0d was not accepted within 200 cycles", w);
      end
    end
    @(negedge clk);
    tx_s_tvalid = 1'b0;
    tx_s_tdest = ~cur.dest;
    tx_s_tuser = ~cur.user;
  endtask

  task automatic watch_stream(input bit rx_path);
    logic [`HDR_DATA_W+`HDR_KEEP_W:0] ew;
    logic [`HDR_DATA_W-1:0] d;
    logic [`HDR_KEEP_W-1:0] k;
    logic [`HDR_DEST_W-1:0] ds;
    logic [`HDR_USER_W-1:0] us;
    logic l;
    string port;
    bit v;
    bit done;
    int idle;
    port = rx_path ? "rx_m" : "tx_m";
    done = 1'b0;
    idle = 0;
    while (!done && idle < 200) begin
      @(posedge clk);
      idle++;
      v = rx_path ? (rx_m_tvalid && rx_m_tready) : (tx_m_tvalid && tx_m_tready);
      d = rx_path ? rx_m_tdata : tx_m_tdata;
      k = rx_path ? rx_m_tkeep : tx_m_tkeep;
      l = rx_path ? rx_m_tlast : tx_m_tlast;
      ds = rx_path ? rx_m_tdest : tx_m_tdest;
      us = rx_path ? rx_m_tuser : tx_m_tuser;
      if (v) begin
        idle = 0;
        done = l;
        if ((rx_path ? exp_rx.size() : exp_tx.size()) == 0) begin
          err_count++;
          $display("%s sent a word beyond the end of the expected packet", port);
        end else begin
          if (rx_path) ew = exp_rx.pop_front();
          else ew = exp_tx.pop_front();
          check_word(port, ew[`HDR_DATA_W-1:0], ew[`HDR_DATA_W +: `HDR_KEEP_W],
                     ew[`HDR_DATA_W+`HDR_KEEP_W], d, k, l);
          check_side(port, cur.dest, cur.user, ds, us);
        end
      end
    end
    if (!done) begin
      err_count++;
      timed_out = 1'b1;
      $display("timeout: no transfer on %s within 200 cycles", port);
    end else if ((rx_path ? exp_rx.size() : exp_tx.size()) != 0) begin
      err_count++;
      $display("%s packet ended before all expected words arrived", port);
    end
  endtask

  task automatic apb_selftest();
    logic [31:0] rd;
    int errs_before;
    errs_before = err_count;
    apb_read(CSR_CTRL, rd);
    check_state_free(CSR_CTRL, 32'd0, rd);
    apb_read(CSR_TX_HDR, rd);
    check_state_free(CSR_TX_HDR, 32'd0, rd);
    apb_read(CSR_RX_HDR, rd);
    check_state_free(CSR_RX_HDR, 32'd0, rd);
    apb_read(CSR_COUNTS, rd);
    check_state_free(CSR_COUNTS, 32'd0, rd);
    apb_write(CSR_CTRL, 32'h3);
    apb_read(CSR_CTRL, rd);
    check_state_free(CSR_CTRL, 32'h3, rd);
    apb_write(CSR_TX_HDR, 32'hc0de_5a17);
    apb_read(CSR_TX_HDR, rd);
    check_state_free(CSR_TX_HDR, 32'hc0de_5a17, rd);
    apb_write(CSR_CTRL, 32'h0);
    $display("apb reset values and read-back: %s", (err_count == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic add_row(input int len, input bit add, input bit strip,
                         input logic [31:0] hdr, input logic [3:0] dest, input logic [3:0] user,
                         input bit bp);
    row_t r;
    r.len = len;
    r.add = add;
    r.strip = strip;
    r.hdr = hdr;
    r.dest = dest;
    r.user = user;
    r.bp = bp;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Pass-through with both enables clear
    add_row(1, 0, 0, 32'h1111_0001, 4'h1, 4'h2, 0);
    add_row(8, 0, 0, 32'h1111_0002, 4'h3, 4'h4, 0);
    add_row(20, 0, 0, 32'h1111_0003, 4'h5, 4'h6, 0);
    // Header added, lengths with and without a tail word
    add_row(3, 1, 0, 32'ha1b2_c3d4, 4'h7, 4'h8, 0);
    add_row(4, 1, 0, 32'h0403_0201, 4'h9, 4'ha, 0);
    add_row(5, 1, 0, 32'hdead_beef, 4'hb, 4'hc, 0);
    add_row(8, 1, 0, 32'h8765_4321, 4'hd, 4'he, 0);
    add_row(13, 1, 0, 32'h5a5a_a5a5, 4'hf, 4'h1, 0);
    // Full loopback, added then stripped
    add_row(1, 1, 1, 32'h1357_9bdf, 4'h2, 4'h3, 0);
    add_row(4, 1, 1, 32'h2468_ace0, 4'h4, 4'h5, 0);
    add_row(9, 1, 1, 32'hfeed_f00d, 4'h6, 4'h7, 0);
    add_row(16, 1, 1, 32'h0bad_cafe, 4'h8, 4'h9, 0);
    add_row(21, 1, 1, 32'h7e57_0021, 4'ha, 4'hb, 0);
    // Loopback with receive back-pressure
    add_row(2, 1, 1, 32'h3c3c_0002, 4'hc, 4'hd, 1);
    add_row(7, 1, 1, 32'h3c3c_0007, 4'he, 4'hf, 1);
    add_row(12, 1, 1, 32'h3c3c_000c, 4'h0, 4'h1, 1);
    add_row(24, 1, 1, 32'h3c3c_0018, 4'h2, 4'h3, 1);
    add_row(5, 1, 1, 32'h3c3c_0005, 4'h4, 4'h5, 1);
    // Framed packets through the remover with stripping off
    add_row(6, 1, 0, 32'h9999_0006, 4'h6, 4'h7, 1);
    add_row(17, 1, 0, 32'h9999_0011, 4'h8, 4'h9, 1);
  endtask

  task automatic run_row(input int idx);
    logic [31:0] rd;
    logic [7:0] b;
    int errs_before;
    cur = rows[idx];
    errs_before = err_count;
    apb_write(CSR_CTRL, {30'd0, cur.strip, cur.add});
    apb_write(CSR_TX_HDR, cur.hdr);
    for (int i = 0; i < cur.len; i++) begin
      rand_byte(b);
      pay[i] = b;
    end
    exp_tx.delete();
    exp_rx.delete();
    expect_stream(1'b0, cur.len + (cur.add ? `HDR_HKEEP_W : 0));
    expect_stream(1'b1, cur.len + ((cur.add && !cur.strip) ? `HDR_HKEEP_W : 0));
    bp_on <= cur.bp;
    fork
      drive_packet();
      watch_stream(1'b0);
      watch_stream(1'b1);
    join
    bp_on <= 1'b0;
    if (cur.add) exp_tx_cnt = exp_tx_cnt + 16'd1;
    exp_rx_cnt = exp_rx_cnt + 16'd1;
    apb_read(CSR_COUNTS, rd);
    check_count("tx_count", exp_tx_cnt, rd[15:0]);
    check_count("rx_count", exp_rx_cnt, rd[31:16]);
    if (cur.strip) begin
      apb_read(CSR_RX_HDR, rd);
      check_hdr("rx_header", cur.hdr, rd);
    end
    $display("row %0d len %0d add %0b strip %0b bp %0b: %s", idx, cur.len, cur.add,
             cur.strip, cur.bp, (err_count == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int cnt;
    tx_s_tdata = '0;
    tx_s_tkeep = '0;
    tx_s_tdest = '0;
    tx_s_tuser = '0;
    tx_s_tlast = 1'b0;
    tx_s_tvalid = 1'b0;
    rx_m_tready = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    bp_on = 1'b0;
    pay_lfsr = 32'h79ef;
    rdy_lfsr = 32'h79ef;
    exp_tx_cnt = '0;
    exp_rx_cnt = '0;
    err_count = 0;
    n_checks = 0;
    timed_out = 1'b0;
    build_table();
    cnt = 0;
    while (rst && cnt < 200) begin
      @(negedge clk);
      cnt++;
    end
    if (rst) begin
      err_count++;
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end
    if (!timed_out) apb_selftest();
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      run_row(i);
    end
    $display("%0d checks, %0d errors", n_checks, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/hdr_pkg.sv
verilog/header_adder.sv
verilog/header_remover.sv
verilog/hdr_csr.sv
verilog/hdr_encap_top.sv
test/tb_clock.sv
test/tb_hdr_encap.sv

// ==== Bender.yml ====
package:
  name: hdr_encap

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hdr_pkg.sv
      - verilog/header_adder.sv
      - verilog/header_remover.sv
      - verilog/hdr_csr.sv
      - verilog/hdr_encap_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock.sv
      - test/tb_hdr_encap.sv
